// File: hdl/ts_pkg.sv
// sprite engine definitions
package ts_pkg;

	// fixed by the descriptor format
	localparam int num_sprites = 42;
	localparam int desc_words  = 3;
	localparam int fifo_depth  = 4;
	localparam int px_per_word = 4;

	// scanner states
	localparam logic [2:0] sc_idle  = 3'd0;
	localparam logic [2:0] sc_rd_r1 = 3'd1;
	localparam logic [2:0] sc_test  = 3'd2;
	localparam logic [2:0] sc_rd_r0 = 3'd3;
	localparam logic [2:0] sc_rd_r2 = 3'd4;
	localparam logic [2:0] sc_wait  = 3'd5;
	localparam logic [2:0] sc_done  = 3'd6;

	// R0: X position, width, X flip, palette
	typedef struct packed {
		logic [3:0] pal;
		logic       xflp;
		logic [1:0] xsz;
		logic [8:0] xcrd;
	} desc_r0_t;

	// R1: Y position, height, Y flip, enable
	typedef struct packed {
		logic       leap;
		logic       act;
		logic [1:0] unused;
		logic       yflp;
		logic [1:0] ysz;
		logic [8:0] ycrd;
	} desc_r1_t;

	// one descriptor word, R2 is taken raw
	typedef union packed {
		desc_r0_t    r0;
		desc_r1_t    r1;
		logic [15:0] raw;
	} sfys_word_u;

	typedef struct packed {
		logic [20:0] row_addr;
		logic [5:0]  words;
		logic [8:0]  x_start;
		logic        xflp;
		logic [3:0]  pal;
	} sprite_job_t;

	// line buffer write, data is palette and pixel
	typedef struct packed {
		logic [8:0] addr;
		logic [7:0] data;
	} tsbuf_wr_t;

endpackage

// File: hdl/sprite_desc_ram.sv
// sprite descriptor memory
`timescale 1ns/1ns

module sprite_desc_ram import ts_pkg::*; (
	input  logic        clk,
	input  logic        we,
	input  logic [6:0]  wr_addr,
	input  logic [15:0] wr_data,
	input  logic [6:0]  rd_addr,
	output sfys_word_u  rd_data
);

	logic [15:0] mem [0:127];

	// three words per sprite at 3n+k
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// registered read port
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: hdl/sprite_scanner.sv
// sprite descriptor scanner
`timescale 1ns/1ns

module sprite_scanner import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        line_start,
	input  logic [8:0]  lcount,
	input  logic        sprite_en,
	input  sfys_word_u  rd_data,
	input  logic        fetch_busy,
	output logic [6:0]  rd_addr,
	output logic        job_stb,
	output sprite_job_t job,
	output logic        line_done
);

	logic [2:0] state;
	logic [5:0] sprite_idx;
	logic [8:0] line_r;
	logic [5:0] row_r;
	desc_r0_t   r0_r;
	logic [1:0] word_sel;
	logic [9:0] y_top;
	logic [9:0] y_line;
	logic [6:0] height;
	logic [5:0] y_off;
	logic [5:0] row_sel;
	logic       covers;
	logic       last_sprite;
	logic [5:0] row_words;
	logic [9:0] row_off;

	// address of the next word, data shows up one state later
	always_comb
	begin
		case (state)
			sc_rd_r1: word_sel = 2'd1;
			sc_test:  word_sel = 2'd0;
			default:  word_sel = 2'd2;
		endcase
		rd_addr = 7'(sprite_idx) * 7'(desc_words) + 7'(word_sel);
	end

	// coverage test on R1, all in 10 bits
	always_comb
	begin
		height = {1'b0, rd_data.r1.ysz, 4'b0000} + 7'd16;
		y_top = {1'b0, rd_data.r1.ycrd};
		y_line = {1'b0, line_r};
		covers = rd_data.r1.act && (y_line >= y_top) && (y_line < y_top + 10'(height));
		y_off = 6'(y_line - y_top);
		if (rd_data.r1.yflp)
			row_sel = 6'(height - 7'd1 - 7'(y_off));
		else
			row_sel = y_off;
	end

	assign last_sprite = sprite_idx == 6'(num_sprites - 1);

	// row length from latched R0, 4 words per 16 pixels
	assign row_words = {2'b00, r0_r.xsz, 2'b00} + 6'd4;
	assign row_off = 10'(row_r) * 10'(row_words);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= sc_idle;
			sprite_idx <= '0;
			job_stb <= 1'b0;
			line_done <= 1'b0;
		end
		else
		begin
			job_stb <= 1'b0;
			line_done <= 1'b0;
			case (state)
				sc_idle:
					if (line_start)
					begin
						sprite_idx <= '0;
						state <= sprite_en ? sc_rd_r1 : sc_done;
					end
				sc_rd_r1:
					state <= sc_test;
				sc_test:
					if (covers)
						state <= sc_rd_r0;
					else if (last_sprite)
						state <= sc_done;
					else
					begin
						sprite_idx <= sprite_idx + 6'd1;
						state <= sc_rd_r1;
					end
				sc_rd_r0:
					state <= sc_rd_r2;
				sc_rd_r2:
				begin
					job_stb <= 1'b1;
					state <= sc_wait;
				end
				sc_wait:
					// busy rises one cycle after the strobe
					if (!job_stb && !fetch_busy)
					begin
						if (last_sprite)
							state <= sc_done;
						else
						begin
							sprite_idx <= sprite_idx + 6'd1;
							state <= sc_rd_r1;
						end
					end
				sc_done:
				begin
					line_done <= 1'b1;
					state <= sc_idle;
				end
				default:
					state <= sc_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == sc_idle && line_start)
			line_r <= lcount;
		if (state == sc_test)
			row_r <= row_sel;
		if (state == sc_rd_r0)
			r0_r <= rd_data.r0;
		if (state == sc_rd_r2)
		begin
			// R2 bits 15..1 are the base in 64-word units
			job.row_addr <= {rd_data.raw[15:1], 6'b000000} + 21'(row_off);
			job.words <= row_words;
			job.x_start <= r0_r.xcrd;
			job.xflp <= r0_r.xflp;
			job.pal <= r0_r.pal;
		end
	end

endmodule

// File: hdl/row_fetcher.sv
// sprite row DRAM fetcher
`timescale 1ns/1ns

module row_fetcher import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        job_stb,
	input  sprite_job_t job,
	input  logic        ts_next,
	input  logic        ts_strobe,
	input  logic [15:0] ts_data,
	input  logic        word_done,
	output logic        ts_req,
	output logic [20:0] ts_addr,
	output logic        fetch_busy,
	output logic        word_stb,
	output logic [15:0] word,
	output sprite_job_t word_ctx
);

	logic [5:0] req_cnt;
	logic [5:0] fin_cnt;
	// accepted and not yet unpacked
	logic [2:0] inflight;
	logic       accept;

	assign ts_req = fetch_busy && (req_cnt != word_ctx.words) &&
		(inflight < 3'(fifo_depth));
	assign accept = ts_req && ts_next;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_busy <= 1'b0;
			req_cnt <= '0;
			fin_cnt <= '0;
			inflight <= '0;
			word_stb <= 1'b0;
		end
		else
		begin
			word_stb <= fetch_busy && ts_strobe;
			if (job_stb)
			begin
				fetch_busy <= 1'b1;
				req_cnt <= '0;
				fin_cnt <= '0;
				inflight <= '0;
			end
			else
			begin
				if (accept)
					req_cnt <= req_cnt + 6'd1;
				case ({accept, word_done})
					2'b10:   inflight <= inflight + 3'd1;
					2'b01:   inflight <= inflight - 3'd1;
					default: inflight <= inflight;
				endcase
				if (word_done)
				begin
					fin_cnt <= fin_cnt + 6'd1;
					// last word of the row written
					if (fin_cnt + 6'd1 == word_ctx.words)
						fetch_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (job_stb)
		begin
			word_ctx <= job;
			ts_addr <= job.row_addr;
		end
		else if (accept)
			ts_addr <= ts_addr + 21'd1;
		if (ts_strobe)
			word <= ts_data;
	end

endmodule

// File: hdl/pixel_unpacker.sv
// sprite pixel unpacker
`timescale 1ns/1ns

module pixel_unpacker import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        word_stb,
	input  logic [15:0] word,
	input  sprite_job_t word_ctx,
	output logic        word_done,
	output logic        tsbuf_we,
	output tsbuf_wr_t   tsbuf_wr
);

	logic [15:0] fifo_mem [0:fifo_depth-1];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic [$clog2(fifo_depth):0]   fifo_cnt;
	logic [15:0] cur_word;
	logic        busy;
	logic [1:0]  nib;
	logic [5:0]  pix_idx;
	logic [6:0]  width;
	logic [8:0]  pix_x;
	logic        last_nib;
	logic        pop;

	assign width = 7'(word_ctx.words) * 7'(px_per_word);
	assign last_nib = busy && (nib == 2'd3);
	assign pop = (fifo_cnt != '0) && (!busy || last_nib);

	// mirrored placement for X flip, wraps at 512
	always_comb
	begin
		if (word_ctx.xflp)
			pix_x = word_ctx.x_start + 9'(width) - 9'd1 - 9'(pix_idx);
		else
			pix_x = word_ctx.x_start + 9'(pix_idx);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			busy <= 1'b0;
			nib <= '0;
			pix_idx <= '0;
			word_done <= 1'b0;
			tsbuf_we <= 1'b0;
		end
		else
		begin
			word_done <= last_nib;
			// zero pixels are transparent
			tsbuf_we <= busy && (cur_word[3:0] != 4'd0);
			if (word_stb)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({word_stb, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
			if (pop)
				busy <= 1'b1;
			else if (last_nib)
				busy <= 1'b0;
			if (busy)
			begin
				nib <= nib + 2'd1;
				// index restarts after the row's last pixel
				if (7'(pix_idx) + 7'd1 == width)
					pix_idx <= '0;
				else
					pix_idx <= pix_idx + 6'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (word_stb)
			fifo_mem[wr_ptr] <= word;
		// low nibble first
		if (pop)
			cur_word <= fifo_mem[rd_ptr];
		else if (busy)
			cur_word <= cur_word >> 4;
		if (busy)
		begin
			tsbuf_wr.addr <= pix_x;
			tsbuf_wr.data <= {word_ctx.pal, cur_word[3:0]};
		end
	end

endmodule

// File: hdl/ts_unit.sv
// sprite line engine top
`timescale 1ns/1ns

module ts_unit import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        desc_we,
	input  logic [6:0]  desc_addr,
	input  logic [15:0] desc_data,
	input  logic        line_start,
	input  logic [8:0]  lcount,
	input  logic        sprite_en,
	input  logic [15:0] ts_data,
	input  logic        ts_next,
	input  logic        ts_strobe,
	output logic        ts_req,
	output logic [20:0] ts_addr,
	output logic        tsbuf_we,
	output tsbuf_wr_t   tsbuf_wr,
	output logic        line_done
);

	logic [6:0]  rd_addr;
	sfys_word_u  rd_data;
	logic        job_stb;
	sprite_job_t job;
	logic        fetch_busy;
	logic        word_stb;
	logic [15:0] word;
	sprite_job_t word_ctx;
	logic        word_done;

	sprite_desc_ram u_desc_ram (
		.clk     (clk),
		.we      (desc_we),
		.wr_addr (desc_addr),
		.wr_data (desc_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	sprite_scanner u_scanner (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.lcount     (lcount),
		.sprite_en  (sprite_en),
		.rd_data    (rd_data),
		.fetch_busy (fetch_busy),
		.rd_addr    (rd_addr),
		.job_stb    (job_stb),
		.job        (job),
		.line_done  (line_done)
	);

	row_fetcher u_fetcher (
		.clk        (clk),
		.rst_n      (rst_n),
		.job_stb    (job_stb),
		.job        (job),
		.ts_next    (ts_next),
		.ts_strobe  (ts_strobe),
		.ts_data    (ts_data),
		.word_done  (word_done),
		.ts_req     (ts_req),
		.ts_addr    (ts_addr),
		.fetch_busy (fetch_busy),
		.word_stb   (word_stb),
		.word       (word),
		.word_ctx   (word_ctx)
	);

	pixel_unpacker u_unpacker (
		.clk       (clk),
		.rst_n     (rst_n),
		.word_stb  (word_stb),
		.word      (word),
		.word_ctx  (word_ctx),
		.word_done (word_done),
		.tsbuf_we  (tsbuf_we),
		.tsbuf_wr  (tsbuf_wr)
	);

endmodule

// File: tests/ts_unit_tb.sv
// sprite line engine testbench
`timescale 1ns/1ns

module ts_unit_tb import ts_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        desc_we;
	logic [6:0]  desc_addr;
	logic [15:0] desc_data;
	logic        line_start;
	logic [8:0]  lcount;
	logic        sprite_en;
	logic [15:0] ts_data;
	logic        ts_next;
	logic        ts_strobe;
	logic        ts_req;
	logic [20:0] ts_addr;
	logic        tsbuf_we;
	tsbuf_wr_t   tsbuf_wr;
	logic        line_done;

	// model state
	logic [31:0] rng_state;
	logic [15:0] desc_mem [0:127];
	logic [7:0]  exp_buf [0:511];
	logic [7:0]  cap_buf [0:511];
	logic [20:0] exp_addr [$];
	logic [20:0] ret_addr [$];
	int          ret_due [$];
	int          nz_q [$];
	int          exp_words;
	int          acc_cnt;
	int          words_written;
	int          cycle;
	int          acc_wait;
	logic [20:0] held_addr;
	logic        line_off;
	logic        long_delays;
	string       test_name;

	ts_unit u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.desc_we    (desc_we),
		.desc_addr  (desc_addr),
		.desc_data  (desc_data),
		.line_start (line_start),
		.lcount     (lcount),
		.sprite_en  (sprite_en),
		.ts_data    (ts_data),
		.ts_next    (ts_next),
		.ts_strobe  (ts_strobe),
		.ts_req     (ts_req),
		.ts_addr    (ts_addr),
		.tsbuf_we   (tsbuf_we),
		.tsbuf_wr   (tsbuf_wr),
		.line_done  (line_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// memory contents as a hash of the address, with frequent zero nibbles
	function automatic logic [15:0] dram_word(input logic [20:0] addr);
		logic [31:0] h;
		h = {11'd0, addr} * 32'h9e3779b1;
		h = h ^ (h >> 15);
		return h[31:16] & (h[15:0] | 16'h8888);
	endfunction

	function automatic int nonzero_pixels(input logic [15:0] w);
		int c;
		c = 0;
		for (int k = 0; k < 4; k++)
			if (w[4*k +: 4] != 4'd0)
				c++;
		return c;
	endfunction

	task automatic stop_on_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error: test %s, %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
			stop_on_failure();
		end
	endtask

	// a word counts as written once all its non-zero pixels came out
	task automatic retire_written();
		while (nz_q.size() != 0 && nz_q[0] == 0)
		begin
			void'(nz_q.pop_front());
			words_written++;
		end
	endtask

	task automatic watch_outputs();
		if (line_off && (ts_req || tsbuf_we))
		begin
			$display("disabled line still requested DRAM or wrote the line buffer");
			stop_on_failure();
		end
		else if (tsbuf_we)
		begin
			cap_buf[tsbuf_wr.addr] = tsbuf_wr.data;
			if (nz_q.size() == 0)
			begin
				$display("line buffer written with no returned DRAM word pending");
				stop_on_failure();
			end
			else
			begin
				nz_q[0] = nz_q[0] - 1;
				retire_written();
			end
		end
	endtask

	task automatic drive_dram();
		// ts_next high last cycle means the request was taken
		if (ts_next)
		begin
			acc_cnt++;
			ret_addr.push_back(held_addr);
			if (long_delays)
				ret_due.push_back(cycle + 8 + int'(next_rand() % 9));
			else
				ret_due.push_back(cycle + 1 + int'(next_rand() % 6));
			ts_next = 1'b0;
			acc_wait = int'(next_rand() % 4);
		end
		if (acc_cnt - words_written > fifo_depth)
		begin
			$display("%0d DRAM words accepted and not yet written, limit is four",
				acc_cnt - words_written);
			stop_on_failure();
		end
		if (ts_req && !ts_next)
		begin
			if (exp_addr.size() == 0)
			begin
				$display("DRAM request beyond the expected sprite rows");
				stop_on_failure();
			end
			else if (acc_wait == 0)
			begin
				check("DRAM address", 32'(exp_addr[0]), 32'(ts_addr));
				void'(exp_addr.pop_front());
				held_addr = ts_addr;
				ts_next = 1'b1;
			end
			else
				acc_wait--;
		end
		// returns in request order
		ts_strobe = 1'b0;
		if (ret_addr.size() != 0 && ret_due[0] <= cycle)
		begin
			ts_strobe = 1'b1;
			ts_data = dram_word(ret_addr[0]);
			nz_q.push_back(nonzero_pixels(ts_data));
			void'(ret_addr.pop_front());
			void'(ret_due.pop_front());
			retire_written();
		end
	endtask

	task automatic tick();
		@(negedge clk);
		cycle++;
		watch_outputs();
		drive_dram();
	endtask

	task automatic write_desc(input int addr, input logic [15:0] data);
		desc_mem[addr] = data;
		desc_we = 1'b1;
		desc_addr = 7'(addr);
		desc_data = data;
		tick();
		desc_we = 1'b0;
	endtask

	task automatic set_sprite(input int n, input logic [8:0] xcrd, input logic [1:0] xsz,
		input logic xflp, input logic [3:0] pal, input logic [8:0] ycrd,
		input logic [1:0] ysz, input logic yflp, input logic act);
		write_desc(3*n, {pal, xflp, xsz, xcrd});
		write_desc(3*n + 1, {1'b0, act, 2'b00, yflp, ysz, ycrd});
		write_desc(3*n + 2, next_rand() >> 16);
	endtask

	task automatic clear_sprites();
		for (int n = 0; n < num_sprites; n++)
			write_desc(3*n + 1, 16'h0000);
	endtask

	// sprites placed around the line so that many of them cover it
	task automatic fill_random(input int line);
		logic [15:0] r1;
		int off;
		for (int n = 0; n < num_sprites; n++)
		begin
			off = int'(next_rand() % 80);
			r1 = next_rand() >> 8;
			r1[8:0] = 9'(line - off);
			r1[14] = (next_rand() % 4) != 0;
			write_desc(3*n, next_rand() >> 12);
			write_desc(3*n + 1, r1);
			write_desc(3*n + 2, next_rand() >> 4);
		end
	endtask

	task automatic build_model(input int line, input logic en);
		logic [15:0] r0;
		logic [15:0] r1;
		logic [15:0] data;
		logic [20:0] row_addr;
		logic [20:0] addr;
		int ycrd;
		int height;
		int off;
		int row;
		int words;
		int width;
		int i;
		int x;
		for (int a = 0; a < 512; a++)
			exp_buf[a] = 8'd0;
		exp_addr.delete();
		exp_words = 0;
		for (int n = 0; n < num_sprites && en; n++)
		begin
			r0 = desc_mem[3*n];
			r1 = desc_mem[3*n + 1];
			ycrd = int'(r1[8:0]);
			height = 16 * (int'(r1[10:9]) + 1);
			if (r1[14] && line >= ycrd && line < ycrd + height)
			begin
				off = line - ycrd;
				row = r1[11] ? height - 1 - off : off;
				words = 4 * (int'(r0[10:9]) + 1);
				width = 4 * words;
				row_addr = 21'(int'(desc_mem[3*n + 2][15:1]) * 64 + row * words);
				for (int w = 0; w < words; w++)
				begin
					addr = row_addr + 21'(w);
					exp_addr.push_back(addr);
					exp_words++;
					data = dram_word(addr);
					for (int k = 0; k < 4; k++)
					begin
						i = 4*w + k;
						if (r0[11])
							x = (int'(r0[8:0]) + width - 1 - i) % 512;
						else
							x = (int'(r0[8:0]) + i) % 512;
						if (data[4*k +: 4] != 4'd0)
							exp_buf[x] = {r0[15:12], data[4*k +: 4]};
					end
				end
			end
		end
	endtask

	task automatic run_line(input int line, input logic en);
		int acc_start;
		int t;
		logic done;
		build_model(line, en);
		for (int a = 0; a < 512; a++)
			cap_buf[a] = 8'd0;
		line_off = !en;
		acc_start = acc_cnt;
		line_start = 1'b1;
		lcount = 9'(line);
		sprite_en = en;
		tick();
		line_start = 1'b0;
		done = 1'b0;
		t = 0;
		while (!done)
		begin
			// generous bound for 42 sprites with slow returns
			if (t == 20000)
			begin
				$display("timeout: no line_done in test %s, line %0d", test_name, line);
				stop_on_failure();
			end
			tick();
			t++;
			done = line_done;
		end
		line_off = 1'b0;
		check("accepted DRAM words", 32'(exp_words), 32'(acc_cnt - acc_start));
		check("words left in DRAM model", 32'd0, 32'(ret_addr.size()));
		for (int a = 0; a < 512; a++)
			check($sformatf("line buffer[%0d]", a), 32'(exp_buf[a]), 32'(cap_buf[a]));
	endtask

	initial
	begin
		rng_state = 32'haee76368;
		rst_n = 1'b0;
		desc_we = 1'b0;
		desc_addr = '0;
		desc_data = '0;
		line_start = 1'b0;
		lcount = '0;
		sprite_en = 1'b0;
		ts_data = '0;
		ts_next = 1'b0;
		ts_strobe = 1'b0;
		line_off = 1'b0;
		long_delays = 1'b0;
		acc_cnt = 0;
		words_written = 0;
		cycle = 0;
		acc_wait = 0;
		held_addr = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		tick();

		test_name = "reset";
		check("ts_req", 32'd0, 32'(ts_req));
		check("tsbuf_we", 32'd0, 32'(tsbuf_we));
		check("line_done", 32'd0, 32'(line_done));

		test_name = "random_draw";
		for (int r = 0; r < 3; r++)
		begin
			lcount = 9'(next_rand());
			fill_random(int'(lcount));
			run_line(int'(lcount), 1'b1);
		end

		// sprites straddling the right edge, plain and mirrored
		test_name = "x_flip_wrap";
		clear_sprites();
		set_sprite(0, 9'd500, 2'd1, 1'b0, 4'd3, 9'd40, 2'd0, 1'b0, 1'b1);
		set_sprite(1, 9'd505, 2'd0, 1'b1, 4'd5, 9'd40, 2'd0, 1'b0, 1'b1);
		set_sprite(2, 9'd490, 2'd3, 1'b1, 4'd9, 9'd30, 2'd1, 1'b1, 1'b1);
		set_sprite(3, 9'd510, 2'd2, 1'b0, 4'd12, 9'd45, 2'd0, 1'b1, 1'b1);
		run_line(45, 1'b1);
		run_line(50, 1'b1);

		test_name = "coverage_edge";
		clear_sprites();
		set_sprite(5, 9'd16, 2'd1, 1'b0, 4'd1, 9'd100, 2'd1, 1'b0, 1'b1);
		set_sprite(6, 9'd80, 2'd1, 1'b1, 4'd2, 9'd100, 2'd1, 1'b1, 1'b1);
		set_sprite(7, 9'd200, 2'd3, 1'b0, 4'd4, 9'd100, 2'd1, 1'b0, 1'b0);
		set_sprite(8, 9'd300, 2'd0, 1'b0, 4'd6, 9'd480, 2'd3, 1'b0, 1'b1);
		run_line(100, 1'b1);
		run_line(131, 1'b1);
		run_line(132, 1'b1);
		run_line(511, 1'b1);
		run_line(20, 1'b1);

		test_name = "back_pressure";
		long_delays = 1'b1;
		for (int r = 0; r < 2; r++)
		begin
			lcount = 9'(next_rand());
			fill_random(int'(lcount));
			run_line(int'(lcount), 1'b1);
		end
		long_delays = 1'b0;

		test_name = "disabled_line";
		run_line(int'(lcount), 1'b0);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: tb.f
hdl/ts_pkg.sv
hdl/sprite_desc_ram.sv
hdl/sprite_scanner.sv
hdl/row_fetcher.sv
hdl/pixel_unpacker.sv
hdl/ts_unit.sv
tests/ts_unit_tb.sv
